/* logic/switch_pkg.sv */
package switch_pkg;

    localparam int NUM_PORTS  = 4;
    localparam int NUM_PRIO   = 8;
    localparam int PAGE_WORDS = 8;
    localparam int NUM_PAGES  = 16;

    typedef logic [15:0] word_t;
    typedef logic [1:0]  port_idx_t;
    typedef logic [2:0]  prio_t;
    typedef logic [3:0]  page_t;
    typedef logic [2:0]  word_idx_t;

    // Header word fields
    localparam int DEST_LSB = 0;
    localparam int PRIO_LSB = 4;

    // Word address inside the shared buffer
    typedef struct packed {
        page_t     page;
        word_idx_t word;
    } buf_addr_t;

    typedef struct packed {
        page_t     page;
        word_idx_t last_word;
    } pkt_desc_t;

    typedef struct packed {
        logic      valid;
        port_idx_t dest;
        prio_t     prio;
        pkt_desc_t desc;
    } enq_req_t;

endpackage

/* logic/ingress_port.sv */
module ingress_port (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_sop,
    input  logic                  wr_eop,
    input  logic                  wr_vld,
    input  switch_pkg::word_t     wr_data,
    output logic                  full,
    output logic                  alloc_req,
    input  logic                  alloc_gnt,
    input  switch_pkg::page_t     alloc_page,
    output logic                  wr_en,
    output switch_pkg::buf_addr_t wr_addr,
    output switch_pkg::word_t     wr_data_out,
    output switch_pkg::enq_req_t  enq,
    input  logic                  enq_gnt
);

    typedef enum logic [1:0] {NEED_PAGE, IDLE, RECEIVE, ENQUEUE} state_t;

    state_t                state;
    switch_pkg::page_t     page;
    switch_pkg::word_idx_t cnt;
    switch_pkg::port_idx_t dest;
    switch_pkg::prio_t     prio;
    switch_pkg::pkt_desc_t desc_q;
    logic                  got_page;

    assign full        = !(state == IDLE || state == RECEIVE);
    assign alloc_req   = (state == NEED_PAGE) || (state == ENQUEUE && !got_page);
    assign wr_en       = wr_vld && ((state == IDLE && wr_sop) || state == RECEIVE);
    assign wr_addr     = '{page: page, word: cnt};
    assign wr_data_out = wr_data;
    assign enq         = '{valid: state == ENQUEUE, dest: dest, prio: prio, desc: desc_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= NEED_PAGE;
            cnt      <= '0;
            got_page <= 1'b0;
        end else begin
            case (state)
                NEED_PAGE: begin
                    if (alloc_gnt) begin
                        state <= IDLE;
                    end
                end
                IDLE, RECEIVE: begin
                    if (wr_en) begin
                        cnt      <= wr_eop ? '0 : cnt + 1'b1;
                        got_page <= 1'b0;
                        state    <= wr_eop ? ENQUEUE : RECEIVE;
                    end
                end
                ENQUEUE: begin
                    if (alloc_gnt) begin
                        got_page <= 1'b1;
                    end
                    // Leave once queued; wait on the pool if no page came yet
                    if (enq_gnt) begin
                        state <= (got_page || alloc_gnt) ? IDLE : NEED_PAGE;
                    end
                end
                default: state <= NEED_PAGE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_gnt) begin
            page <= alloc_page;
        end
        if (wr_en && state == IDLE) begin
            dest <= switch_pkg::port_idx_t'(wr_data >> switch_pkg::DEST_LSB);
            prio <= switch_pkg::prio_t'(wr_data >> switch_pkg::PRIO_LSB);
        end
        if (wr_en && wr_eop) begin
            desc_q <= '{page: page, last_word: cnt};
        end
    end

endmodule

/* logic/page_pool.sv */
module page_pool #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS,
    parameter int NUM_PAGES = switch_pkg::NUM_PAGES
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [NUM_PORTS-1:0]              alloc_req,
    output logic [NUM_PORTS-1:0]              alloc_gnt,
    output switch_pkg::page_t                 alloc_page,
    input  logic [NUM_PORTS-1:0]              release_en,
    input  switch_pkg::page_t [NUM_PORTS-1:0] release_page
);

    logic [NUM_PAGES-1:0]  free_map;
    logic [NUM_PAGES-1:0]  released;
    logic [NUM_PAGES-1:0]  taken;
    logic                  page_avail;
    logic                  gnt_vld;
    switch_pkg::port_idx_t gnt_idx;
    switch_pkg::port_idx_t rr_ptr;

    // Lowest free page
    always_comb begin
        page_avail = 1'b0;
        alloc_page = '0;
        for (int i = NUM_PAGES - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                page_avail = 1'b1;
                alloc_page = switch_pkg::page_t'(i);
            end
        end
    end

    // First requester at or after rr_ptr
    always_comb begin
        gnt_vld = 1'b0;
        gnt_idx = rr_ptr;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (!gnt_vld && alloc_req[(int'(rr_ptr) + i) % NUM_PORTS]) begin
                gnt_vld = 1'b1;
                gnt_idx = switch_pkg::port_idx_t'((int'(rr_ptr) + i) % NUM_PORTS);
            end
        end
        gnt_vld            = gnt_vld && page_avail;
        alloc_gnt          = '0;
        alloc_gnt[gnt_idx] = gnt_vld;
    end

    always_comb begin
        released = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (release_en[p]) begin
                released[release_page[p]] = 1'b1;
            end
        end
        taken = gnt_vld ? (NUM_PAGES'(1) << alloc_page) : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_map <= '1;
            rr_ptr   <= '0;
        end else begin
            free_map <= (free_map | released) & ~taken;
            if (gnt_vld) begin
                rr_ptr <= switch_pkg::port_idx_t'((int'(gnt_idx) + 1) % NUM_PORTS);
            end
        end
    end

endmodule

/* logic/packet_buffer.sv */
module packet_buffer #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS,
    parameter int NUM_PAGES = switch_pkg::NUM_PAGES
) (
    input  logic                                  clk,
    input  logic [NUM_PORTS-1:0]                  wr_en,
    input  switch_pkg::buf_addr_t [NUM_PORTS-1:0] wr_addr,
    input  switch_pkg::word_t [NUM_PORTS-1:0]     wr_data,
    input  logic [NUM_PORTS-1:0]                  rd_en,
    input  switch_pkg::buf_addr_t [NUM_PORTS-1:0] rd_addr,
    output switch_pkg::word_t [NUM_PORTS-1:0]     rd_data
);

    switch_pkg::word_t mem [NUM_PAGES * switch_pkg::PAGE_WORDS];

    // Each page belongs to one input at a time so writes never collide
    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr_en[p]) begin
                mem[wr_addr[p]] <= wr_data[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rd_en[p]) begin
                rd_data[p] <= mem[rd_addr[p]];
            end
        end
    end

endmodule

/* logic/queue_manager.sv */
module queue_manager #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS,
    parameter int NUM_PAGES = switch_pkg::NUM_PAGES
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  switch_pkg::enq_req_t [NUM_PORTS-1:0] enq,
    output logic [NUM_PORTS-1:0]                 enq_gnt,
    input  logic [NUM_PORTS-1:0]                 deq_en,
    input  switch_pkg::prio_t [NUM_PORTS-1:0]    deq_prio,
    output logic [NUM_PORTS-1:0][switch_pkg::NUM_PRIO-1:0] not_empty,
    output switch_pkg::pkt_desc_t [NUM_PORTS-1:0][switch_pkg::NUM_PRIO-1:0] head
);

    localparam int NUM_PRIO = switch_pkg::NUM_PRIO;
    localparam int PTR_W    = $clog2(NUM_PAGES);
    localparam int CNT_W    = $clog2(NUM_PAGES + 1);

    switch_pkg::pkt_desc_t fifo_mem [NUM_PORTS][NUM_PRIO][NUM_PAGES];

    logic [NUM_PORTS-1:0][NUM_PRIO-1:0][PTR_W-1:0] wr_ptr;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0][PTR_W-1:0] rd_ptr;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0][CNT_W-1:0] count;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0]            push;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0]            pop;
    switch_pkg::port_idx_t                         rr_ptr;
    switch_pkg::port_idx_t                         gnt_idx;
    logic                                          gnt_vld;
    switch_pkg::enq_req_t                          sel;

    // One enqueue per cycle in round robin over the inputs
    always_comb begin
        gnt_vld = 1'b0;
        gnt_idx = rr_ptr;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (!gnt_vld && enq[(int'(rr_ptr) + i) % NUM_PORTS].valid) begin
                gnt_vld = 1'b1;
                gnt_idx = switch_pkg::port_idx_t'((int'(rr_ptr) + i) % NUM_PORTS);
            end
        end
        enq_gnt          = '0;
        enq_gnt[gnt_idx] = gnt_vld;
        sel              = enq[gnt_idx];
    end

    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int q = 0; q < NUM_PRIO; q++) begin
                push[o][q]      = gnt_vld && sel.dest == o && sel.prio == q;
                pop[o][q]       = deq_en[o] && deq_prio[o] == q;
                not_empty[o][q] = count[o][q] != '0;
                head[o][q]      = fifo_mem[o][q][rd_ptr[o][q]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            rr_ptr <= '0;
        end else begin
            if (gnt_vld) begin
                rr_ptr <= switch_pkg::port_idx_t'((int'(gnt_idx) + 1) % NUM_PORTS);
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                for (int q = 0; q < NUM_PRIO; q++) begin
                    if (push[o][q]) begin
                        wr_ptr[o][q] <= wr_ptr[o][q] + 1'b1;
                    end
                    if (pop[o][q]) begin
                        rd_ptr[o][q] <= rd_ptr[o][q] + 1'b1;
                    end
                    count[o][q] <= count[o][q] + CNT_W'(push[o][q]) - CNT_W'(pop[o][q]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (gnt_vld) begin
            fifo_mem[sel.dest][sel.prio][wr_ptr[sel.dest][sel.prio]] <= sel.desc;
        end
    end

endmodule

/* logic/egress_port.sv */
module egress_port (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             wrr_en,
    input  logic                                             ready,
    input  logic [switch_pkg::NUM_PRIO-1:0]                  not_empty,
    input  switch_pkg::pkt_desc_t [switch_pkg::NUM_PRIO-1:0] head,
    output logic                                             deq_en,
    output switch_pkg::prio_t                                deq_prio,
    output logic                                             rd_en,
    output switch_pkg::buf_addr_t                            rd_addr,
    input  switch_pkg::word_t                                rd_data_in,
    output logic                                             release_en,
    output switch_pkg::page_t                                release_page,
    output logic                                             rd_sop,
    output logic                                             rd_eop,
    output logic                                             rd_vld,
    output switch_pkg::word_t                                rd_data
);

    localparam int NUM_PRIO = switch_pkg::NUM_PRIO;

    typedef enum logic {IDLE, READ} state_t;

    state_t                state;
    switch_pkg::pkt_desc_t cur;
    switch_pkg::word_idx_t idx;
    logic [NUM_PRIO-1:0]   wrr_mask;
    logic [NUM_PRIO-1:0]   masked;
    logic [NUM_PRIO-1:0]   cand;
    logic [NUM_PRIO-1:0]   sel_bit;

    // Fall back to the full set when the mask leaves nothing
    assign masked = not_empty & wrr_mask;
    assign cand   = (wrr_en && masked != '0) ? masked : not_empty;

    always_comb begin
        deq_prio = '0;
        for (int i = NUM_PRIO - 1; i >= 0; i--) begin
            if (cand[i]) begin
                deq_prio = switch_pkg::prio_t'(i);
            end
        end
    end

    assign sel_bit = NUM_PRIO'(1) << deq_prio;
    assign deq_en  = state == IDLE && ready && not_empty != '0;
    assign rd_en   = state == READ;
    assign rd_addr = '{page: cur.page, word: idx};

    // Page goes back to the pool as the last word leaves
    assign release_en   = rd_eop;
    assign release_page = cur.page;
    assign rd_data      = rd_data_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            idx      <= '0;
            wrr_mask <= '1;
            rd_vld   <= 1'b0;
            rd_sop   <= 1'b0;
            rd_eop   <= 1'b0;
        end else begin
            rd_vld <= rd_en;
            rd_sop <= rd_en && idx == '0;
            rd_eop <= rd_en && idx == cur.last_word;
            case (state)
                IDLE: begin
                    if (deq_en) begin
                        state <= READ;
                        if (wrr_en) begin
                            wrr_mask <= (masked != '0 ? wrr_mask : '1) & ~sel_bit;
                        end
                    end
                end
                READ: begin
                    if (idx == cur.last_word) begin
                        idx   <= '0;
                        state <= IDLE;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (deq_en) begin
            cur <= head[deq_prio];
        end
    end

endmodule

/* logic/switch_top.sv */
module switch_top #(
    parameter int NUM_PORTS = switch_pkg::NUM_PORTS,
    parameter int NUM_PAGES = switch_pkg::NUM_PAGES
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              wrr_en,
    input  logic [NUM_PORTS-1:0]              wr_sop,
    input  logic [NUM_PORTS-1:0]              wr_eop,
    input  logic [NUM_PORTS-1:0]              wr_vld,
    input  switch_pkg::word_t [NUM_PORTS-1:0] wr_data,
    output logic [NUM_PORTS-1:0]              full,
    input  logic [NUM_PORTS-1:0]              ready,
    output logic [NUM_PORTS-1:0]              rd_sop,
    output logic [NUM_PORTS-1:0]              rd_eop,
    output logic [NUM_PORTS-1:0]              rd_vld,
    output switch_pkg::word_t [NUM_PORTS-1:0] rd_data
);

    logic [NUM_PORTS-1:0]                  alloc_req;
    logic [NUM_PORTS-1:0]                  alloc_gnt;
    switch_pkg::page_t                     alloc_page;
    logic [NUM_PORTS-1:0]                  buf_wr_en;
    switch_pkg::buf_addr_t [NUM_PORTS-1:0] buf_wr_addr;
    switch_pkg::word_t [NUM_PORTS-1:0]     buf_wr_data;
    switch_pkg::enq_req_t [NUM_PORTS-1:0]  enq;
    logic [NUM_PORTS-1:0]                  enq_gnt;
    logic [NUM_PORTS-1:0]                  deq_en;
    switch_pkg::prio_t [NUM_PORTS-1:0]     deq_prio;
    logic [NUM_PORTS-1:0]                  buf_rd_en;
    switch_pkg::buf_addr_t [NUM_PORTS-1:0] buf_rd_addr;
    switch_pkg::word_t [NUM_PORTS-1:0]     buf_rd_data;
    logic [NUM_PORTS-1:0]                  release_en;
    switch_pkg::page_t [NUM_PORTS-1:0]     release_page;

    logic [NUM_PORTS-1:0][switch_pkg::NUM_PRIO-1:0]                  not_empty;
    switch_pkg::pkt_desc_t [NUM_PORTS-1:0][switch_pkg::NUM_PRIO-1:0] head;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_ingress
        ingress_port u_ingress_port (
            .clk         (clk),
            .rst_n       (rst_n),
            .wr_sop      (wr_sop[p]),
            .wr_eop      (wr_eop[p]),
            .wr_vld      (wr_vld[p]),
            .wr_data     (wr_data[p]),
            .full        (full[p]),
            .alloc_req   (alloc_req[p]),
            .alloc_gnt   (alloc_gnt[p]),
            .alloc_page  (alloc_page),
            .wr_en       (buf_wr_en[p]),
            .wr_addr     (buf_wr_addr[p]),
            .wr_data_out (buf_wr_data[p]),
            .enq         (enq[p]),
            .enq_gnt     (enq_gnt[p])
        );
    end

    page_pool #(.NUM_PORTS(NUM_PORTS), .NUM_PAGES(NUM_PAGES)) u_page_pool (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_req    (alloc_req),
        .alloc_gnt    (alloc_gnt),
        .alloc_page   (alloc_page),
        .release_en   (release_en),
        .release_page (release_page)
    );

    packet_buffer #(.NUM_PORTS(NUM_PORTS), .NUM_PAGES(NUM_PAGES)) u_packet_buffer (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_en   (buf_rd_en),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    queue_manager #(.NUM_PORTS(NUM_PORTS), .NUM_PAGES(NUM_PAGES)) u_queue_manager (
        .clk       (clk),
        .rst_n     (rst_n),
        .enq       (enq),
        .enq_gnt   (enq_gnt),
        .deq_en    (deq_en),
        .deq_prio  (deq_prio),
        .not_empty (not_empty),
        .head      (head)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_egress
        egress_port u_egress_port (
            .clk          (clk),
            .rst_n        (rst_n),
            .wrr_en       (wrr_en),
            .ready        (ready[p]),
            .not_empty    (not_empty[p]),
            .head         (head[p]),
            .deq_en       (deq_en[p]),
            .deq_prio     (deq_prio[p]),
            .rd_en        (buf_rd_en[p]),
            .rd_addr      (buf_rd_addr[p]),
            .rd_data_in   (buf_rd_data[p]),
            .release_en   (release_en[p]),
            .release_page (release_page[p]),
            .rd_sop       (rd_sop[p]),
            .rd_eop       (rd_eop[p]),
            .rd_vld       (rd_vld[p]),
            .rd_data      (rd_data[p])
        );
    end

endmodule

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each entry holds phase, source port, destination, priority, length and output order
typedef struct packed {
    logic [2:0] phase;
    logic [1:0] src;
    logic [1:0] dest;
    logic [2:0] prio;
    logic [3:0] len;
    logic [3:0] order;
} vec_t;

localparam int N_VEC = 35;

localparam vec_t VECTORS [N_VEC] = '{
    '{3'd1, 2'd0, 2'd0, 3'd0, 4'd1, 4'd0},
    '{3'd1, 2'd0, 2'd1, 3'd0, 4'd2, 4'd0},
    '{3'd1, 2'd0, 2'd2, 3'd0, 4'd3, 4'd0},
    '{3'd1, 2'd0, 2'd3, 3'd0, 4'd4, 4'd0},
    '{3'd1, 2'd0, 2'd0, 3'd0, 4'd5, 4'd1},
    '{3'd1, 2'd0, 2'd1, 3'd0, 4'd6, 4'd1},
    '{3'd1, 2'd0, 2'd2, 3'd0, 4'd7, 4'd1},
    '{3'd1, 2'd0, 2'd3, 3'd0, 4'd8, 4'd1},
    '{3'd2, 2'd0, 2'd3, 3'd0, 4'd3, 4'd0},
    '{3'd2, 2'd1, 2'd2, 3'd1, 4'd4, 4'd0},
    '{3'd2, 2'd2, 2'd1, 3'd2, 4'd5, 4'd0},
    '{3'd2, 2'd3, 2'd0, 3'd3, 4'd6, 4'd0},
    '{3'd3, 2'd0, 2'd0, 3'd5, 4'd2, 4'd1},
    '{3'd3, 2'd0, 2'd0, 3'd2, 4'd3, 4'd0},
    '{3'd3, 2'd0, 2'd0, 3'd7, 4'd4, 4'd2},
    '{3'd4, 2'd1, 2'd1, 3'd1, 4'd2, 4'd0},
    '{3'd4, 2'd1, 2'd1, 3'd1, 4'd3, 4'd2},
    '{3'd4, 2'd1, 2'd1, 3'd3, 4'd4, 4'd1},
    '{3'd4, 2'd1, 2'd1, 3'd3, 4'd2, 4'd3},
    '{3'd5, 2'd0, 2'd0, 3'd6, 4'd8, 4'd0},
    '{3'd5, 2'd0, 2'd0, 3'd6, 4'd8, 4'd1},
    '{3'd5, 2'd0, 2'd0, 3'd6, 4'd8, 4'd2},
    '{3'd5, 2'd0, 2'd0, 3'd6, 4'd8, 4'd3},
    '{3'd5, 2'd1, 2'd1, 3'd6, 4'd8, 4'd0},
    '{3'd5, 2'd1, 2'd1, 3'd6, 4'd8, 4'd1},
    '{3'd5, 2'd1, 2'd1, 3'd6, 4'd8, 4'd2},
    '{3'd5, 2'd1, 2'd1, 3'd6, 4'd8, 4'd3},
    '{3'd5, 2'd2, 2'd2, 3'd6, 4'd8, 4'd0},
    '{3'd5, 2'd2, 2'd2, 3'd6, 4'd8, 4'd1},
    '{3'd5, 2'd2, 2'd2, 3'd6, 4'd8, 4'd2},
    '{3'd5, 2'd2, 2'd2, 3'd6, 4'd8, 4'd3},
    '{3'd5, 2'd3, 2'd3, 3'd6, 4'd8, 4'd0},
    '{3'd5, 2'd3, 2'd3, 3'd6, 4'd8, 4'd1},
    '{3'd5, 2'd3, 2'd3, 3'd6, 4'd8, 4'd2},
    '{3'd5, 2'd3, 2'd3, 3'd6, 4'd8, 4'd3}
};

`endif

/* test/switch_tb.sv */
`include "tb_vectors.svh"

module switch_tb;

    localparam int NUM_PORTS = switch_pkg::NUM_PORTS;

    logic                              clk;
    logic                              rst_n;
    logic                              wrr_en;
    logic [NUM_PORTS-1:0]              wr_sop;
    logic [NUM_PORTS-1:0]              wr_eop;
    logic [NUM_PORTS-1:0]              wr_vld;
    switch_pkg::word_t [NUM_PORTS-1:0] wr_data;
    logic [NUM_PORTS-1:0]              full;
    logic [NUM_PORTS-1:0]              ready;
    logic [NUM_PORTS-1:0]              rd_sop;
    logic [NUM_PORTS-1:0]              rd_eop;
    logic [NUM_PORTS-1:0]              rd_vld;
    switch_pkg::word_t [NUM_PORTS-1:0] rd_data;

    switch_pkg::word_t pkt_data [N_VEC][switch_pkg::PAGE_WORDS];
    int                exp_q [NUM_PORTS][$];
    int                cur [NUM_PORTS];
    int                widx [NUM_PORTS];
    logic              busy [NUM_PORTS];
    int                errors;
    int                tests_passed;
    int                tests_failed;
    int                cycles;
    int                limit;
    integer            seed;

    switch_top #(.NUM_PORTS(NUM_PORTS)) u_switch_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .wrr_en  (wrr_en),
        .wr_sop  (wr_sop),
        .wr_eop  (wr_eop),
        .wr_vld  (wr_vld),
        .wr_data (wr_data),
        .full    (full),
        .ready   (ready),
        .rd_sop  (rd_sop),
        .rd_eop  (rd_eop),
        .rd_vld  (rd_vld),
        .rd_data (rd_data)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not complete within %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Fail at time %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
            errors = errors + 1;
        end
    endtask

    // Output monitors sample away from the rising edge
    always @(negedge clk) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (rst_n && !rd_vld[o] && (rd_sop[o] || rd_eop[o])) begin
                $display("Error: output %0d raised rd_sop or rd_eop without rd_vld", o);
                errors = errors + 1;
            end
            if (rd_vld[o] && !busy[o]) begin
                if (exp_q[o].size() == 0) begin
                    $display("Error: output %0d delivered a word nobody sent", o);
                    errors = errors + 1;
                end else begin
                    cur[o]  = exp_q[o].pop_front();
                    busy[o] = 1'b1;
                    widx[o] = 0;
                end
            end else if (!rd_vld[o] && busy[o]) begin
                $display("Error: output %0d dropped rd_vld inside a packet", o);
                errors = errors + 1;
            end
            if (rd_vld[o] && busy[o]) begin
                check(rd_sop[o], widx[o] == 0, $sformatf("rd_sop on output %0d", o));
                check(rd_eop[o], widx[o] == VECTORS[cur[o]].len - 1,
                      $sformatf("rd_eop on output %0d", o));
                check(rd_data[o], pkt_data[cur[o]][widx[o]],
                      $sformatf("word %0d of entry %0d on output %0d", widx[o], cur[o], o));
                if (widx[o] == VECTORS[cur[o]].len - 1) begin
                    busy[o] = 1'b0;
                end else begin
                    widx[o] = widx[o] + 1;
                end
            end
        end
    end

    function automatic logic pending();
        logic any;
        any = 1'b0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (busy[o] || exp_q[o].size() != 0) begin
                any = 1'b1;
            end
        end
        return any;
    endfunction

    task automatic send_packet(input int src, input int entry);
        while (full[src]) begin
            @(negedge clk);
        end
        for (int w = 0; w < VECTORS[entry].len; w++) begin
            wr_vld[src]  = 1'b1;
            wr_sop[src]  = (w == 0);
            wr_eop[src]  = (w == VECTORS[entry].len - 1);
            wr_data[src] = pkt_data[entry][w];
            @(negedge clk);
        end
        wr_vld[src] = 1'b0;
        wr_sop[src] = 1'b0;
        wr_eop[src] = 1'b0;
    endtask

    task automatic drive_source(input int phase, input int src);
        for (int i = 0; i < N_VEC; i++) begin
            if (VECTORS[i].phase == phase && VECTORS[i].src == src) begin
                send_packet(src, i);
            end
        end
    endtask

    task automatic run_phase(input int phase, input string name);
        int errs_before;
        errs_before = errors;
        while (full != '0) begin
            @(negedge clk);
        end
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int k = 0; k < 16; k++) begin
                for (int i = 0; i < N_VEC; i++) begin
                    if (VECTORS[i].phase == phase && VECTORS[i].dest == o &&
                        VECTORS[i].order == k) begin
                        exp_q[o].push_back(i);
                    end
                end
            end
        end
        wrr_en = (phase == 4);
        ready  = (phase >= 3) ? '0 : '1;
        for (int s = 0; s < NUM_PORTS; s++) begin
            automatic int src = s;
            fork
                drive_source(phase, src);
            join_none
        end
        wait fork;
        if (phase >= 3) begin
            // Let the last enqueue settle before opening the outputs
            repeat (10) @(negedge clk);
            if (phase == 5) begin
                check(full, {NUM_PORTS{1'b1}}, "full on every port with the buffer used up");
            end
            ready = '1;
        end
        while (pending()) begin
            @(negedge clk);
        end
        if (phase == 5) begin
            while (full != '0) begin
                @(negedge clk);
            end
        end
        if (errors == errs_before) begin
            tests_passed = tests_passed + 1;
            $display("Test %0d %s: passed", phase, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %0d %s: failed", phase, name);
        end
    endtask

    initial begin
        int total_words;
        rst_n        = 1'b0;
        wrr_en       = 1'b0;
        ready        = '0;
        wr_sop       = '0;
        wr_eop       = '0;
        wr_vld       = '0;
        wr_data      = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles       = 0;
        seed         = 32'h139db806;
        total_words  = 0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            busy[o] = 1'b0;
        end
        // Header carries dest and prio and the rest is random payload
        for (int i = 0; i < N_VEC; i++) begin
            total_words = total_words + VECTORS[i].len;
            for (int w = 0; w < switch_pkg::PAGE_WORDS; w++) begin
                pkt_data[i][w] = switch_pkg::word_t'($random(seed));
            end
            pkt_data[i][0][1:0] = VECTORS[i].dest;
            pkt_data[i][0][3:2] = 2'b00;
            pkt_data[i][0][6:4] = VECTORS[i].prio;
        end
        limit = 50 * total_words + 500;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Reset state is checked first while the switch is quiet
        while (full != '0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        check(full, '0, "full after reset");
        if (errors == 0) begin
            tests_passed = tests_passed + 1;
            $display("Test 6 reset state: passed");
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test 6 reset state: failed");
        end

        run_phase(1, "forwarding");
        run_phase(2, "parallelism");
        run_phase(3, "strict priority");
        run_phase(4, "weighted round robin");
        run_phase(5, "back-pressure");

        $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+include
logic/switch_pkg.sv
logic/ingress_port.sv
logic/page_pool.sv
logic/packet_buffer.sv
logic/queue_manager.sv
logic/egress_port.sv
logic/switch_top.sv
test/switch_tb.sv

/* Bender.yml */
package:
  name: switch

sources:
  - logic/switch_pkg.sv
  - logic/ingress_port.sv
  - logic/page_pool.sv
  - logic/packet_buffer.sv
  - logic/queue_manager.sv
  - logic/egress_port.sv
  - logic/switch_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - test/switch_tb.sv
